/* hdl/armPkg.sv */
// Widths, register indices, flag positions and the enum types of the ARM core
package armPkg;

   // Machine word and register number widths
   localparam int dataWidth    = 32;
   localparam int regAddrWidth = 4;

   localparam int pcRegIdx   = 15;  // R15 reads as PC+8
   localparam int linkRegIdx = 14;  // BL return address
   localparam int pcStep     = 4;   // Bytes per instruction

   // Bit positions inside the 4-bit NZCV word
   localparam int flagN = 3;
   localparam int flagZ = 2;
   localparam int flagC = 1;
   localparam int flagV = 0;

   typedef logic [dataWidth-1:0] dataWord;

   // Instruction class, bits 27:26
   typedef enum logic [1:0] {
      opDataProc = 2'b00,
      opMemory   = 2'b01,
      opBranch   = 2'b10
   } opType;

   typedef enum logic [2:0] {
      aluAdd = 3'd0,
      aluSub = 3'd1,
      aluAnd = 3'd2,
      aluOrr = 3'd3,
      aluEor = 3'd4
   } aluOp;

   // ARM condition field, bits 31:28
   typedef enum logic [3:0] {
      condEq = 4'b0000,  // Z set
      condNe = 4'b0001,  // Z clear
      condCs = 4'b0010,  // C set
      condCc = 4'b0011,  // C clear
      condMi = 4'b0100,  // N set
      condPl = 4'b0101,  // N clear
      condVs = 4'b0110,  // V set
      condVc = 4'b0111,  // V clear
      condHi = 4'b1000,  // Unsigned higher
      condLs = 4'b1001,  // Unsigned lower or same
      condGe = 4'b1010,  // Signed >=
      condLt = 4'b1011,  // Signed <
      condGt = 4'b1100,  // Signed >
      condLe = 4'b1101,  // Signed <=
      condAl = 4'b1110   // Always
   } condCode;

   // Immediate extension kinds
   typedef enum logic [1:0] {
      immByte   = 2'b00,  // imm8, zero extended
      immOffset = 2'b01,  // imm12, zero extended
      immBranch = 2'b10   // imm24, sign extended, times 4
   } immKind;

endpackage

/* hdl/alu.sv */
// ALU with shared add/subtract adder, logic operations and NZCV generation
`timescale 1ns/10ps

module alu import armPkg::*; (
   input  dataWord    a,
   input  dataWord    b,
   input  aluOp       aluControl,
   output dataWord    result,
   output logic [3:0] aluFlags
);

   localparam int msb = dataWidth - 1;

   logic               isSub;
   logic               isArith;
   dataWord            condInvB;
   logic [dataWidth:0] sum;       // Carry out on top

   assign isSub   = (aluControl == aluSub);
   assign isArith = (aluControl == aluAdd) | isSub;

   // a - b as a + ~b + 1
   assign condInvB = isSub ? ~b : b;
   assign sum      = {1'b0, a} + {1'b0, condInvB} + {{dataWidth{1'b0}}, isSub};

   always_comb begin
      case (aluControl)
         aluAdd,
         aluSub:  result = sum[msb:0];
         aluAnd:  result = a & b;
         aluOrr:  result = a | b;
         aluEor:  result = a ^ b;
         default: result = '0;
      endcase
   end

   assign aluFlags[flagN] = result[msb];
   assign aluFlags[flagZ] = (result == '0);
   assign aluFlags[flagC] = isArith & sum[dataWidth];
   // Operands of effective same sign, result sign differs
   assign aluFlags[flagV] = isArith & ~(a[msb] ^ b[msb] ^ isSub) & (a[msb] ^ sum[msb]);

endmodule

/* hdl/regFile.sv */
// Fifteen-entry register file with two read ports, one write port and R15 read override
`timescale 1ns/10ps

module regFile import armPkg::*; (
   input  logic                    clk,
   input  logic                    we,
   input  logic [regAddrWidth-1:0] ra1,
   input  logic [regAddrWidth-1:0] ra2,
   input  logic [regAddrWidth-1:0] wa,
   input  dataWord                 wd,
   input  dataWord                 r15,   // PC+8 from the datapath
   output dataWord                 rd1,
   output dataWord                 rd2
);

   dataWord regs [pcRegIdx];  // R0 to R14

   logic wrPc;

   // R15 is the PC register, never stored here
   assign wrPc = (wa == regAddrWidth'(pcRegIdx));

   always_ff @(posedge clk) begin
      if (we && !wrPc) regs[wa] <= wd;
   end

   // Combinational reads
   assign rd1 = (ra1 == regAddrWidth'(pcRegIdx)) ? r15 : regs[ra1];
   assign rd2 = (ra2 == regAddrWidth'(pcRegIdx)) ? r15 : regs[ra2];

endmodule

/* hdl/armDecoder.sv */
// Main decoder and ALU decoder producing the control levels of the core
`timescale 1ns/10ps

module armDecoder import armPkg::*; (
   input  opType                   op,
   input  logic [5:0]              funct,       // Instruction bits 25:20
   input  logic [regAddrWidth-1:0] rd,
   output logic [2:0]              regSrc,      // {link write, rd as read 2, R15 as read 1}
   output immKind                  immSrc,
   output logic                    aluSrc,      // Immediate operand
   output logic                    memToReg,
   output logic                    pcS,
   output logic                    regW,
   output logic                    memW,
   output logic                    noWrite,     // Compare, result discarded
   output logic                    memAccess,
   output logic [1:0]              flagW,       // {NZ, CV}
   output aluOp                    aluControl
);

   logic branch;
   logic aluDecode;  // Data processing, ALU decoder in charge
   logic dpValid;    // Known data processing opcode

   // Main decoder
   always_comb begin
      regSrc    = 3'b000;
      immSrc    = immByte;
      aluSrc    = 1'b0;
      memToReg  = 1'b0;
      regW      = 1'b0;
      memW      = 1'b0;
      memAccess = 1'b0;
      branch    = 1'b0;
      aluDecode = 1'b0;
      case (op)
         opDataProc: begin
            aluSrc    = funct[5];  // I bit
            regW      = 1'b1;
            aluDecode = 1'b1;
         end
         opMemory: begin
            immSrc    = immOffset;
            aluSrc    = 1'b1;
            memAccess = 1'b1;
            if (funct[0]) begin  // LDR
               memToReg = 1'b1;
               regW     = 1'b1;
            end else begin       // STR, rd goes out on read port 2
               regSrc[1] = 1'b1;
               memW      = 1'b1;
            end
         end
         opBranch: begin
            regSrc[0] = 1'b1;      // Base is PC+8
            regSrc[2] = funct[4];  // BL writes R14
            regW      = funct[4];
            immSrc    = immBranch;
            aluSrc    = 1'b1;
            branch    = 1'b1;
         end
         default: ;  // Unsupported class, nothing written
      endcase
   end

   // ALU decoder
   always_comb begin
      aluControl = aluAdd;  // Address and target adds
      noWrite    = 1'b0;
      dpValid    = 1'b1;
      if (aluDecode) begin
         case (funct[4:1])
            4'b0100: aluControl = aluAdd;
            4'b0010: aluControl = aluSub;
            4'b0000: aluControl = aluAnd;
            4'b1100: aluControl = aluOrr;
            4'b0001: aluControl = aluEor;
            4'b1010: begin  // CMP
               aluControl = aluSub;
               noWrite    = 1'b1;
               dpValid    = funct[0];
            end
            default: begin  // Not implemented
               noWrite = 1'b1;
               dpValid = 1'b0;
            end
         endcase
      end
   end

   // Flags only on S, and C/V only for arithmetic
   assign flagW[1] = aluDecode & dpValid & funct[0];
   assign flagW[0] = flagW[1] & (aluControl == aluAdd || aluControl == aluSub);

   // Write to R15 jumps, compares write nothing
   assign pcS = branch | (regW & ~noWrite & (rd == regAddrWidth'(pcRegIdx)));

endmodule

/* hdl/condLogic.sv */
// NZCV flag registers, condition evaluation and gating of the write enables
`timescale 1ns/10ps

module condLogic import armPkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  condCode    cond,
   input  logic [3:0] aluFlags,
   input  logic [1:0] flagW,
   input  logic       pcS,
   input  logic       regW,
   input  logic       memW,
   input  logic       noWrite,
   input  logic       memAccess,
   input  logic       pcReady,   // Low holds all architectural state
   output logic       pcSrc,
   output logic       regWrite,
   output logic       memWrite,
   output logic       memStrobe
);

   logic [3:0] flags;      // Stored NZCV
   logic [1:0] flagWrite;
   logic       condEx;     // Condition passes
   logic       ge;

   assign ge = (flags[flagN] == flags[flagV]);

   always_comb begin
      case (cond)
         condEq:  condEx = flags[flagZ];
         condNe:  condEx = ~flags[flagZ];
         condCs:  condEx = flags[flagC];
         condCc:  condEx = ~flags[flagC];
         condMi:  condEx = flags[flagN];
         condPl:  condEx = ~flags[flagN];
         condVs:  condEx = flags[flagV];
         condVc:  condEx = ~flags[flagV];
         condHi:  condEx = flags[flagC] & ~flags[flagZ];
         condLs:  condEx = ~flags[flagC] | flags[flagZ];
         condGe:  condEx = ge;
         condLt:  condEx = ~ge;
         condGt:  condEx = ~flags[flagZ] & ge;
         condLe:  condEx = flags[flagZ] | ~ge;
         condAl:  condEx = 1'b1;
         default: condEx = 1'b0;  // 1111 never executes here
      endcase
   end

   assign flagWrite = flagW & {2{condEx & pcReady}};

   // NZ and CV updated separately
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         flags <= 4'b0000;
      end else begin
         if (flagWrite[1]) flags[flagN:flagZ] <= aluFlags[flagN:flagZ];
         if (flagWrite[0]) flags[flagC:flagV] <= aluFlags[flagC:flagV];
      end
   end

   assign regWrite  = regW & condEx & ~noWrite & pcReady;
   assign memWrite  = memW & condEx & pcReady;
   assign memStrobe = memAccess & condEx;  // Stays up during a stall
   assign pcSrc     = pcS & condEx;

endmodule

/* hdl/armDatapath.sv */
// Datapath with PC register, immediate extender, operand and result muxes, register file and ALU
`timescale 1ns/10ps

module armDatapath import armPkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  dataWord    instr,
   input  logic [2:0] regSrc,
   input  immKind     immSrc,
   input  logic       aluSrc,
   input  logic       memToReg,
   input  logic       regWrite,
   input  logic       pcSrc,
   input  logic       pcReady,
   input  aluOp       aluControl,
   input  dataWord    readData,
   output logic [3:0] aluFlags,
   output dataWord    pc,
   output dataWord    aluResult,
   output dataWord    writeData
);

   dataWord pcNext;
   dataWord pcPlus4;
   dataWord pcPlus8;
   dataWord extImm;
   dataWord srcA;
   dataWord srcB;
   dataWord result;
   dataWord wd;

   logic [regAddrWidth-1:0] ra1;
   logic [regAddrWidth-1:0] ra2;
   logic [regAddrWidth-1:0] wa;

   // Next PC
   assign pcPlus4 = pc + dataWidth'(pcStep);
   assign pcPlus8 = pcPlus4 + dataWidth'(pcStep);
   assign pcNext  = pcSrc ? result : pcPlus4;  // Branch or write to R15

   always_ff @(posedge clk or posedge reset) begin
      if (reset) pc <= '0;
      else if (pcReady) pc <= pcNext;  // Held during a stall
   end

   // Immediate extension
   always_comb begin
      case (immSrc)
         immByte:   extImm = {24'b0, instr[7:0]};
         immOffset: extImm = {20'b0, instr[11:0]};
         immBranch: extImm = {{6{instr[23]}}, instr[23:0], 2'b00};
         default:   extImm = '0;
      endcase
   end

   // Register addresses
   assign ra1 = regSrc[0] ? regAddrWidth'(pcRegIdx) : instr[19:16];     // Branch base
   assign ra2 = regSrc[1] ? instr[15:12] : instr[3:0];                  // STR data
   assign wa  = regSrc[2] ? regAddrWidth'(linkRegIdx) : instr[15:12];   // BL link
   assign wd  = regSrc[2] ? pcPlus4 : result;

   regFile regFile0 (
      .clk (clk),
      .we  (regWrite),
      .ra1 (ra1),
      .ra2 (ra2),
      .wa  (wa),
      .wd  (wd),
      .r15 (pcPlus8),
      .rd1 (srcA),
      .rd2 (writeData)
   );

   assign srcB = aluSrc ? extImm : writeData;

   alu alu0 (
      .a          (srcA),
      .b          (srcB),
      .aluControl (aluControl),
      .result     (aluResult),
      .aluFlags   (aluFlags)
   );

   assign result = memToReg ? readData : aluResult;  // LDR result

endmodule

/* hdl/armCore.sv */
// Top level of the single-cycle core joining decoder, condition logic and datapath
`timescale 1ns/10ps

module armCore import armPkg::*; (
   input  logic    clk,
   input  logic    reset,
   output dataWord pc,
   input  dataWord instr,
   output logic    memWrite,
   output dataWord aluResult,   // Memory address for LDR and STR
   output dataWord writeData,
   input  dataWord readData,
   output logic    memStrobe,
   input  logic    pcReady
);

   logic [3:0] aluFlags;
   logic [2:0] regSrc;
   immKind     immSrc;
   aluOp       aluControl;
   logic [1:0] flagW;
   logic       aluSrc;
   logic       memToReg;
   logic       pcS;
   logic       regW;
   logic       memW;
   logic       noWrite;
   logic       memAccess;
   logic       regWrite;
   logic       pcSrc;

   armDecoder armDecoder0 (
      .op         (opType'(instr[27:26])),
      .funct      (instr[25:20]),
      .rd         (instr[15:12]),
      .regSrc     (regSrc),
      .immSrc     (immSrc),
      .aluSrc     (aluSrc),
      .memToReg   (memToReg),
      .pcS        (pcS),
      .regW       (regW),
      .memW       (memW),
      .noWrite    (noWrite),
      .memAccess  (memAccess),
      .flagW      (flagW),
      .aluControl (aluControl)
   );

   condLogic condLogic0 (
      .clk       (clk),
      .reset     (reset),
      .cond      (condCode'(instr[31:28])),
      .aluFlags  (aluFlags),
      .flagW     (flagW),
      .pcS       (pcS),
      .regW      (regW),
      .memW      (memW),
      .noWrite   (noWrite),
      .memAccess (memAccess),
      .pcReady   (pcReady),
      .pcSrc     (pcSrc),
      .regWrite  (regWrite),
      .memWrite  (memWrite),
      .memStrobe (memStrobe)
   );

   armDatapath armDatapath0 (
      .clk        (clk),
      .reset      (reset),
      .instr      (instr),
      .regSrc     (regSrc),
      .immSrc     (immSrc),
      .aluSrc     (aluSrc),
      .memToReg   (memToReg),
      .regWrite   (regWrite),
      .pcSrc      (pcSrc),
      .pcReady    (pcReady),
      .aluControl (aluControl),
      .readData   (readData),
      .aluFlags   (aluFlags),
      .pc         (pc),
      .aluResult  (aluResult),
      .writeData  (writeData)
   );

endmodule

/* test/armCore_properties.sv */
// Concurrent assertions on memory strobes, stall behavior and PC alignment, bound into armCore
`timescale 1ns/10ps

module armCoreProperties import armPkg::*; (
   input logic    clk,
   input logic    reset,
   input dataWord pc,
   input logic    memWrite,
   input logic    memStrobe,
   input logic    pcReady
);

   int failCount = 0;  // Failed assertion count

   // A write is always a strobed access
   writeHasStrobe: assert property (@(posedge clk) disable iff (reset) memWrite |-> memStrobe)
      else begin
         $error("memWrite high without memStrobe");
         failCount++;
      end

   noWriteInStall: assert property (@(posedge clk) disable iff (reset) !pcReady |-> !memWrite)
      else begin
         $error("memWrite high while pcReady low");
         failCount++;
      end

   // Held PC
   pcHeldInStall: assert property (@(posedge clk) disable iff (reset) !pcReady |=> $stable(pc))
      else begin
         $error("pc changed across a stalled edge");
         failCount++;
      end

   pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
      else begin
         $error("pc not word aligned");
         failCount++;
      end

endmodule

bind armCore armCoreProperties armCoreProperties0 (
   .clk       (clk),
   .reset     (reset),
   .pc        (pc),
   .memWrite  (memWrite),
   .memStrobe (memStrobe),
   .pcReady   (pcReady)
);

/* test/armCoreTb.sv */
// Testbench for armCore with memory models, LFSR stimulus, directed tests, checks and watchdog
`timescale 1ns/10ps

module armCoreTb import armPkg::*; ();

   localparam int cycleNs   = 100;
   localparam int budgetSum = 20 + 60 + 200 + 40 + 40 + 45 + 6 * 4;  // Test budgets plus resets

   logic    clk;
   logic    reset;
   logic    pcReady;
   dataWord instr;
   dataWord readData;
   dataWord pc;
   dataWord aluResult;
   dataWord writeData;
   logic    memWrite;
   logic    memStrobe;

   dataWord imem [256];
   dataWord dmem [256];
   dataWord storeAddr [$];  // Observed stores
   dataWord storeData [$];
   dataWord expAddr [$];    // Expected stores
   dataWord expData [$];
   dataWord trace [$];      // pc per cycle
   dataWord expTrace [$];

   logic [15:0] lfsrState = 16'd16;
   int          testErrors = 0;
   int          errors = 0;
   int          testCount = 0;
   int          failedTests = 0;

   armCore dut0 (
      .clk       (clk),
      .reset     (reset),
      .pc        (pc),
      .instr     (instr),
      .memWrite  (memWrite),
      .aluResult (aluResult),
      .writeData (writeData),
      .readData  (readData),
      .memStrobe (memStrobe),
      .pcReady   (pcReady)
   );

   initial begin
      clk = 1'b0;
      forever #(cycleNs / 2) clk = ~clk;
   end

   // Instruction fetch, data read and store capture around each edge
   initial begin
      forever begin
         @(posedge clk);
         #10 instr = imem[pc[9:2]];
         #10 readData = dmem[aluResult[9:2]];
         #75;  // 5 ns before the next edge
         if (memWrite === 1'b1) begin
            storeAddr.push_back(aluResult);
            storeData.push_back(writeData);
            dmem[aluResult[9:2]] = writeData;
         end
      end
   end

   initial begin
      #(2 * budgetSum * cycleNs);
      $display("Watchdog expired, the tests ran past their cycle budget");
      $display("Test FAILED");
      $finish;
   end

   // Taps 16, 14, 13, 11
   function automatic logic [7:0] randByte();
      logic       fb;
      logic [7:0] v;
      v = '0;
      for (int i = 0; i < 8; i++) begin
         fb        = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
         lfsrState = {lfsrState[14:0], fb};
         v         = {v[6:0], fb};
      end
      return v;
   endfunction

   function automatic dataWord dpInstr(condCode c, logic i, logic [3:0] opc, logic s,
                                       logic [3:0] rn, logic [3:0] rd, logic [11:0] op2);
      return {c, 2'b00, i, opc, s, rn, rd, op2};
   endfunction

   // P=1, U=1, word, no writeback
   function automatic dataWord memInstr(condCode c, logic l, logic [3:0] rn, logic [3:0] rd,
                                        logic [11:0] off);
      return {c, 2'b01, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, l, rn, rd, off};
   endfunction

   function automatic dataWord brInstr(condCode c, logic l, int off);
      return {c, 3'b101, l, 24'(off)};
   endfunction

   function automatic dataWord targetOf(int addr, int off);
      return dataWord'(addr + 8 + off * 4);
   endfunction

   function automatic logic [3:0] armOpcode(aluOp k);
      case (k)
         aluAdd:  return 4'b0100;
         aluSub:  return 4'b0010;
         aluAnd:  return 4'b0000;
         aluOrr:  return 4'b1100;
         default: return 4'b0001;  // EOR
      endcase
   endfunction

   function automatic dataWord expectedAlu(aluOp k, dataWord a, dataWord b);
      case (k)
         aluAdd:  return a + b;
         aluSub:  return a - b;
         aluAnd:  return a & b;
         aluOrr:  return a | b;
         default: return a ^ b;
      endcase
   endfunction

   // ARM condition rules on {N, Z, C, V}
   function automatic logic condHolds(condCode c, logic [3:0] f);
      logic n, z, cf, v;
      {n, z, cf, v} = f;
      case (c)
         condEq:  return z;
         condNe:  return !z;
         condCs:  return cf;
         condCc:  return !cf;
         condMi:  return n;
         condPl:  return !n;
         condVs:  return v;
         condVc:  return !v;
         condHi:  return cf && !z;
         condLs:  return !cf || z;
         condGe:  return n == v;
         condLt:  return n != v;
         condGt:  return !z && (n == v);
         condLe:  return z || (n != v);
         default: return 1'b1;
      endcase
   endfunction

   task automatic compareWord(string name, dataWord exp, dataWord act);
      if (act !== exp) begin
         $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
         testErrors++;
      end
   endtask

   task automatic compareBit(string name, logic exp, logic act);
      if (act !== exp) begin
         $display("Mismatch in %s: expected %b, actual %b", name, exp, act);
         testErrors++;
      end
   endtask

   // Never-executed instruction fill and address-tagged data words
   task automatic loadBlank();
      for (int i = 0; i < 256; i++) begin
         imem[i] = {4'hF, 16'h0, 12'(i)};
         dmem[i] = {20'hDA7A0, 12'(i * 4)};
      end
      imem[0] = dpInstr(condAl, 1'b1, 4'b0000, 1'b0, 4'd15, 4'd0, 12'd0);  // R0 = 0
      expAddr.delete();
      expData.delete();
      trace.delete();
      expTrace.delete();
   endtask

   task automatic movImm(int idx, logic [3:0] rd, logic [7:0] v);
      imem[idx] = dpInstr(condAl, 1'b1, 4'b0100, 1'b0, 4'd0, rd, {4'b0, v});
   endtask

   task automatic haltAt(int idx);
      imem[idx] = brInstr(condAl, 1'b0, -2);  // Branch to self
   endtask

   task automatic startCore();
      @(posedge clk);
      #5 reset = 1'b1;
      pcReady  = 1'b1;
      storeAddr.delete();  // Stores made before this reset
      storeData.delete();
      repeat (3) @(posedge clk);
      #5 reset = 1'b0;
   endtask

   task automatic runToPc(string name, dataWord target, int budget);
      int n;
      n = 0;
      while (pc !== target && n < budget) begin
         trace.push_back(pc);
         @(posedge clk);
         #1 n++;
      end
      if (pc !== target) begin
         $display("%s: pc did not reach %h within %0d cycles", name, target, budget);
         testErrors++;
      end else begin
         trace.push_back(pc);
      end
   endtask

   task automatic checkStores(string name);
      compareWord({name, " store count"}, expAddr.size(), storeAddr.size());
      for (int i = 0; i < expAddr.size() && i < storeAddr.size(); i++) begin
         compareWord({name, " store address"}, expAddr[i], storeAddr[i]);
         compareWord({name, " store data"}, expData[i], storeData[i]);
      end
   endtask

   task automatic checkTrace(string name);
      compareWord({name, " trace length"}, expTrace.size(), trace.size());
      for (int i = 0; i < expTrace.size() && i < trace.size(); i++)
         compareWord({name, " pc"}, expTrace[i], trace[i]);
   endtask

   task automatic endTest(string name);
      testCount++;
      if (testErrors == 0) begin
         $display("%s: passed", name);
      end else begin
         $display("%s: failed with %0d errors", name, testErrors);
         failedTests++;
      end
      errors += testErrors;
      testErrors = 0;
   endtask

   task automatic testReset();
      loadBlank();
      for (int i = 1; i < 6; i++) movImm(i, 4'd1, 8'(i));
      haltAt(6);
      startCore();
      compareWord("reset pc", '0, pc);
      for (int i = 0; i <= 6; i++) expTrace.push_back(dataWord'(i * pcStep));
      runToPc("reset", 24, 20);
      checkTrace("reset");
      endTest("reset");
   endtask

   task automatic testDataProc();
      aluOp       ops [5] = '{aluAdd, aluSub, aluAnd, aluOrr, aluEor};
      logic [7:0] a, b, c;
      int         idx;
      a = randByte();
      b = randByte();
      c = randByte();
      loadBlank();
      movImm(1, 4'd1, a);
      movImm(2, 4'd2, c);
      idx = 3;
      for (int k = 0; k < 5; k++) begin
         imem[idx]     = dpInstr(condAl, 1'b1, armOpcode(ops[k]), 1'b0, 4'd1, 4'd3, {4'b0, b});
         imem[idx + 1] = dpInstr(condAl, 1'b0, armOpcode(ops[k]), 1'b0, 4'd1, 4'd4, 12'd2);
         imem[idx + 2] = memInstr(condAl, 1'b0, 4'd0, 4'd3, 12'(k * 8));
         imem[idx + 3] = memInstr(condAl, 1'b0, 4'd0, 4'd4, 12'(k * 8 + 4));
         expAddr.push_back(k * 8);
         expData.push_back(expectedAlu(ops[k], a, b));
         expAddr.push_back(k * 8 + 4);
         expData.push_back(expectedAlu(ops[k], a, c));
         idx += 4;
      end
      haltAt(idx);
      startCore();
      runToPc("data processing", idx * 4, 60);
      checkStores("data processing");
      endTest("data processing");
   endtask

   task automatic testFlags();
      dataWord    x [3] = '{5, 3, 7};
      dataWord    y [3] = '{5, 7, 3};
      dataWord    diff;
      logic [3:0] f;
      int         idx;
      loadBlank();
      idx = 1;
      for (int p = 0; p < 3; p++) begin
         movImm(idx, 4'd1, 8'(x[p]));
         movImm(idx + 1, 4'd2, 8'(y[p]));
         movImm(idx + 2, 4'd5, 8'h55);  // Marker that CMP must not touch
         imem[idx + 3] = dpInstr(condAl, 1'b0, 4'b1010, 1'b1, 4'd1, 4'd5, 12'd2);
         diff = x[p] - y[p];
         f = {diff[31], diff == 0, x[p] >= y[p], (x[p][31] ^ y[p][31]) & (diff[31] ^ x[p][31])};
         idx += 4;
         for (int c = 0; c < 14; c++) begin
            imem[idx]     = dpInstr(condCode'(c), 1'b1, 4'b0100, 1'b0, 4'd0, 4'd6,
                                    12'(16 * p + c + 1));
            imem[idx + 1] = memInstr(condCode'(c), 1'b0, 4'd0, 4'd6, 12'(p * 64 + c * 4));
            if (condHolds(condCode'(c), f)) begin
               expAddr.push_back(p * 64 + c * 4);
               expData.push_back(16 * p + c + 1);
            end
            idx += 2;
         end
         imem[idx] = memInstr(condAl, 1'b0, 4'd0, 4'd5, 12'(p * 64 + 60));
         expAddr.push_back(p * 64 + 60);
         expData.push_back(32'h55);
         idx++;
      end
      haltAt(idx);
      startCore();
      runToPc("flags", idx * 4, 200);
      checkStores("flags");
      endTest("flags");
   endtask

   task automatic testLoadStore();
      logic [7:0] v1, v2;
      v1 = randByte();
      v2 = randByte();
      loadBlank();
      movImm(1, 4'd7, 8'h80);  // Base register
      movImm(2, 4'd1, v1);
      movImm(3, 4'd2, v2);
      imem[4] = memInstr(condAl, 1'b0, 4'd7, 4'd1, 12'd0);
      imem[5] = memInstr(condAl, 1'b0, 4'd7, 4'd2, 12'd8);
      imem[6] = memInstr(condAl, 1'b1, 4'd7, 4'd3, 12'd0);
      imem[7] = memInstr(condAl, 1'b1, 4'd7, 4'd4, 12'd8);
      imem[8] = memInstr(condAl, 1'b0, 4'd7, 4'd3, 12'd16);
      imem[9] = memInstr(condAl, 1'b0, 4'd7, 4'd4, 12'd20);
      haltAt(10);
      expAddr = '{32'h80, 32'h88, 32'h90, 32'h94};
      expData = '{dataWord'(v1), dataWord'(v2), dataWord'(v1), dataWord'(v2)};
      startCore();
      runToPc("load store", 40, 40);
      checkStores("load store");
      endTest("load store");
   endtask

   task automatic testBranch();
      loadBlank();
      imem[1]  = brInstr(condAl, 1'b0, 1);   // Skips 2 and 3
      movImm(2, 4'd8, 8'hBB);
      imem[3]  = memInstr(condAl, 1'b0, 4'd0, 4'd8, 12'h40);
      imem[4]  = dpInstr(condAl, 1'b1, 4'b1010, 1'b1, 4'd0, 4'd0, 12'd0);  // Z set
      imem[5]  = brInstr(condNe, 1'b0, 1);   // Not taken
      movImm(6, 4'd9, 8'h11);
      imem[7]  = memInstr(condAl, 1'b0, 4'd0, 4'd9, 12'h44);
      imem[8]  = brInstr(condAl, 1'b1, 2);   // BL to 12
      imem[9]  = memInstr(condAl, 1'b0, 4'd0, 4'd14, 12'h48);
      haltAt(10);
      imem[12] = brInstr(condAl, 1'b0, -5);  // Back to 9
      expTrace = '{0, 4, targetOf(4, 1), 20, 24, 28, 32, targetOf(32, 2), targetOf(48, -5), 40};
      expAddr  = '{32'h44, 32'h48};
      expData  = '{32'h11, 32'd36};
      startCore();
      runToPc("branch", 40, 40);
      checkTrace("branch");
      checkStores("branch");
      endTest("branch");
   endtask

   task automatic testStall();
      logic [7:0] v;
      v = randByte();
      loadBlank();
      movImm(1, 4'd1, v);
      imem[2] = memInstr(condAl, 1'b0, 4'd0, 4'd1, 12'h60);
      haltAt(3);
      expAddr.push_back(32'h60);
      expData.push_back(v);
      startCore();
      runToPc("stall", 8, 20);
      #4 pcReady = 1'b0;
      repeat (4) begin
         @(posedge clk);
         #50;
         compareWord("stall pc", 8, pc);
         compareBit("stall memWrite", 1'b0, memWrite);
         compareBit("stall memStrobe", 1'b1, memStrobe);
      end
      compareWord("stall early store count", 0, storeAddr.size());
      @(posedge clk);
      #5 pcReady = 1'b1;
      runToPc("stall", 12, 20);
      checkStores("stall");
      endTest("stall");
   endtask

   initial begin
      reset    = 1'b1;
      pcReady  = 1'b1;
      instr    = '0;
      readData = '0;
      testReset();
      testDataProc();
      testFlags();
      testLoadStore();
      testBranch();
      testStall();
      $display("%0d tests, %0d failed, %0d errors, %0d assertion failures",
               testCount, failedTests, errors, dut0.armCoreProperties0.failCount);
      if (failedTests == 0 && dut0.armCoreProperties0.failCount == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

/* filelist.f */
hdl/armPkg.sv
hdl/alu.sv
hdl/regFile.sv
hdl/armDecoder.sv
hdl/condLogic.sv
hdl/armDatapath.sv
hdl/armCore.sv
test/armCore_properties.sv
test/armCoreTb.sv

/* Bender.yml */
package:
  name: arm_core

sources:
  - hdl/armPkg.sv
  - hdl/alu.sv
  - hdl/regFile.sv
  - hdl/armDecoder.sv
  - hdl/condLogic.sv
  - hdl/armDatapath.sv
  - hdl/armCore.sv
  - target: test
    files:
      - test/armCore_properties.sv
      - test/armCoreTb.sv
